// ==== verilog/rv_pkg.sv ====
package rv_pkg;

    // Operations of the ALU.
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT
    } alu_op_t;

    // Core control states.
    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        FETCH_WAIT,
        DECODE,
        MEM_WAIT,
        HALT
    } cpu_state_t;

    // RISC-V major opcodes.
    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_t;

    // First fetch address and RAM base.
    localparam logic [31:0] RESET_PC = 32'h1000_0000;

endpackage

// ==== verilog/mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if #(
    parameter int ADDR_W = 32
);
    logic [ADDR_W-1:0] addr;
    logic [31:0] write_data;
    logic [3:0] byte_enable;
    logic write_req;
    logic read_req;
    logic ready;
    logic [31:0] read_data;
    logic read_data_valid;

    modport master (
        output addr, write_data, byte_enable, write_req, read_req,
        input ready, read_data, read_data_valid
    );

    modport slave (
        input addr, write_data, byte_enable, write_req, read_req,
        output ready, read_data, read_data_valid
    );
endinterface

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input rv_pkg::alu_op_t op,
    input logic [31:0] lhs,
    input logic [31:0] rhs,
    output logic [31:0] res
);
    import rv_pkg::*;

    always_comb begin
        case (op)
            ADD: res = lhs + rhs;
            SUB: res = lhs - rhs;
            AND: res = lhs & rhs;
            OR:  res = lhs | rhs;
            XOR: res = lhs ^ rhs;
            // Signed compare.
            SLT: res = {31'h0, $signed(lhs) < $signed(rhs)};
            default: res = 32'h0;
        endcase
    end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu (
    input logic clk,
    input logic reset_n,
    input logic run,
    mem_bus_if.master bus,
    output logic halted,
    output logic [31:0] halt_pc
);
    import rv_pkg::*;

    cpu_state_t state;
    cpu_state_t state_next;
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] instr;
    logic [31:0] instr_next;
    logic [31:0] halt_pc_next;
    logic [31:0] addr;
    logic [31:0] addr_next;
    logic [31:0] write_data;
    logic [31:0] write_data_next;
    logic write_req;
    logic write_req_next;
    logic read_req;
    logic read_req_next;

    logic [31:0] regs [1:31];
    logic rf_we;
    logic [31:0] rf_wdata;

    opcode_t opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [31:0] i_imm;
    logic [31:0] s_imm;
    logic [31:0] j_imm;
    logic [31:0] u_imm;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;

    alu_op_t alu_op;
    alu_op_t r_op;
    logic r_ok;
    logic [31:0] alu_rhs;
    logic [31:0] alu_res;

    assign opcode = opcode_t'(instr[6:0]);
    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign s_imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign u_imm = {instr[31:12], 12'h0};

    // x0 reads as zero.
    assign rs1_val = (rs1 == 5'd0) ? 32'h0 : regs[rs1];
    assign rs2_val = (rs2 == 5'd0) ? 32'h0 : regs[rs2];

    assign alu_op = (opcode == OP) ? r_op : ADD;
    assign alu_rhs = (opcode == OP) ? rs2_val : i_imm;

    assign bus.addr = addr;
    assign bus.write_data = write_data;
    assign bus.byte_enable = 4'hf;
    assign bus.write_req = write_req;
    assign bus.read_req = read_req;

    alu u_alu (
        .op(alu_op),
        .lhs(rs1_val),
        .rhs(alu_rhs),
        .res(alu_res)
    );

    // Register-register function decode.
    always_comb begin
        r_op = ADD;
        r_ok = (funct7 == 7'h00);
        case (funct3)
            3'b000: begin
                if (funct7 == 7'h20) begin
                    r_op = SUB;
                    r_ok = 1'b1;
                end
            end
            3'b010: r_op = SLT;
            3'b100: r_op = XOR;
            3'b110: r_op = OR;
            3'b111: r_op = AND;
            default: r_ok = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        pc_next = pc;
        instr_next = instr;
        halt_pc_next = halt_pc;
        addr_next = addr;
        write_data_next = write_data;
        write_req_next = write_req;
        read_req_next = read_req;
        rf_we = 1'b0;
        rf_wdata = 32'h0;

        case (state)
            IDLE: begin
                if (run) begin
                    state_next = FETCH;
                end
            end
            FETCH: begin
                addr_next = pc;
                read_req_next = 1'b1;
                state_next = FETCH_WAIT;
            end
            FETCH_WAIT: begin
                if (bus.ready) begin
                    read_req_next = 1'b0;
                end
                if (bus.read_data_valid) begin
                    instr_next = bus.read_data;
                    state_next = DECODE;
                end
            end
            DECODE: begin
                pc_next = pc + 32'h4;
                state_next = FETCH;
                case (opcode)
                    OP_IMM, OP: begin
                        rf_we = 1'b1;
                        rf_wdata = alu_res;
                        // Only addi among the immediate forms.
                        if ((opcode == OP) ? !r_ok : (funct3 != 3'b000)) begin
                            rf_we = 1'b0;
                            pc_next = pc;
                            halt_pc_next = pc;
                            state_next = HALT;
                        end
                    end
                    LUI: begin
                        rf_we = 1'b1;
                        rf_wdata = u_imm;
                    end
                    JAL: begin
                        rf_we = 1'b1;
                        rf_wdata = pc + 32'h4;
                        pc_next = pc + j_imm;
                    end
                    LOAD, STORE: begin
                        pc_next = pc;
                        if (funct3 == 3'b010) begin
                            addr_next = rs1_val + ((opcode == LOAD) ? i_imm : s_imm);
                            write_data_next = rs2_val;
                            read_req_next = (opcode == LOAD);
                            write_req_next = (opcode == STORE);
                            state_next = MEM_WAIT;
                        end else begin
                            halt_pc_next = pc;
                            state_next = HALT;
                        end
                    end
                    default: begin
                        pc_next = pc;
                        halt_pc_next = pc;
                        state_next = HALT;
                    end
                endcase
            end
            MEM_WAIT: begin
                if (bus.ready) begin
                    read_req_next = 1'b0;
                    write_req_next = 1'b0;
                    if (write_req) begin
                        pc_next = pc + 32'h4;
                        state_next = FETCH;
                    end
                end
                if (bus.read_data_valid) begin
                    rf_we = 1'b1;
                    rf_wdata = bus.read_data;
                    pc_next = pc + 32'h4;
                    state_next = FETCH;
                end
            end
            default: state_next = HALT;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
            pc <= RESET_PC;
            instr <= 32'h0;
            halt_pc <= 32'h0;
            halted <= 1'b0;
            addr <= 32'h0;
            write_data <= 32'h0;
            write_req <= 1'b0;
            read_req <= 1'b0;
        end else begin
            state <= state_next;
            pc <= pc_next;
            instr <= instr_next;
            halt_pc <= halt_pc_next;
            halted <= (state == HALT);
            addr <= addr_next;
            write_data <= write_data_next;
            write_req <= write_req_next;
            read_req <= read_req_next;
        end
    end

    // Writes to x0 are dropped.
    always_ff @(posedge clk) begin
        if (rf_we && rd != 5'd0) begin
            regs[rd] <= rf_wdata;
        end
    end

endmodule

// ==== verilog/host_port.sv ====
`timescale 1ns/1ps

module host_port (
    input logic clk,
    input logic reset_n,
    input logic [31:0] host_addr,
    input logic [31:0] host_write_data,
    input logic host_write,
    input logic host_read,
    output logic host_done,
    output logic [31:0] host_read_data,
    mem_bus_if.master bus
);
    logic [31:0] req_addr;
    logic [31:0] req_data;
    logic req_write;
    logic req_read;
    logic rd_pending;

    assign bus.addr = req_addr;
    assign bus.write_data = req_data;
    assign bus.byte_enable = 4'hf;
    assign bus.write_req = req_write;
    assign bus.read_req = req_read;

    always_ff @(posedge clk) begin
        if (host_write || host_read) begin
            req_addr <= host_addr;
            req_data <= host_write_data;
        end
        if (bus.read_data_valid && rd_pending) begin
            host_read_data <= bus.read_data;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req_write <= 1'b0;
            req_read <= 1'b0;
            rd_pending <= 1'b0;
            host_done <= 1'b0;
        end else begin
            host_done <= 1'b0;
            if (host_write) begin
                req_write <= 1'b1;
            end
            if (host_read) begin
                req_read <= 1'b1;
            end
            // A write completes on acceptance.
            if (bus.ready) begin
                req_write <= 1'b0;
                req_read <= 1'b0;
                rd_pending <= req_read;
                host_done <= req_write;
            end
            if (bus.read_data_valid && rd_pending) begin
                rd_pending <= 1'b0;
                host_done <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter #(
    parameter int RAM_WORDS = 1024
) (
    input logic clk,
    input logic reset_n,
    mem_bus_if.slave m0,
    mem_bus_if.slave m1,
    mem_bus_if.master mem
);
    import rv_pkg::*;

    localparam int OFF_W = $clog2(RAM_WORDS) + 2;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_XFER,
        ARB_RESP
    } arb_state_t;

    arb_state_t state;
    logic owner_core;
    logic last_core;
    logic host_req;
    logic core_req;
    logic pick_core;
    logic sel_core;
    logic fwd;
    logic [31:0] sel_addr;
    logic [31:0] sel_off;

    assign host_req = m0.read_req | m0.write_req;
    assign core_req = m1.read_req | m1.write_req;

    // Core wins a tie only when the host was served last.
    assign pick_core = core_req && (!host_req || !last_core);
    assign sel_core = (state == ARB_IDLE) ? pick_core : owner_core;
    assign fwd = (state == ARB_XFER) || ((state == ARB_IDLE) && (host_req || core_req));

    // Fold the address into the RAM window.
    assign sel_addr = sel_core ? m1.addr : m0.addr;
    assign sel_off = sel_addr - RESET_PC;
    assign mem.addr = RESET_PC + {{(32 - OFF_W){1'b0}}, sel_off[OFF_W-1:0]};
    assign mem.write_data = sel_core ? m1.write_data : m0.write_data;
    assign mem.byte_enable = sel_core ? m1.byte_enable : m0.byte_enable;
    assign mem.read_req = fwd && (sel_core ? m1.read_req : m0.read_req);
    assign mem.write_req = fwd && (sel_core ? m1.write_req : m0.write_req);

    assign m0.ready = fwd && !sel_core && mem.ready;
    assign m1.ready = fwd && sel_core && mem.ready;
    assign m0.read_data = mem.read_data;
    assign m1.read_data = mem.read_data;
    assign m0.read_data_valid = (state == ARB_RESP) && !owner_core && mem.read_data_valid;
    assign m1.read_data_valid = (state == ARB_RESP) && owner_core && mem.read_data_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= ARB_IDLE;
            owner_core <= 1'b0;
            last_core <= 1'b1;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (host_req || core_req) begin
                        owner_core <= pick_core;
                        last_core <= pick_core;
                        if (!mem.ready) begin
                            state <= ARB_XFER;
                        end else if (mem.read_req) begin
                            state <= ARB_RESP;
                        end
                    end
                end
                ARB_XFER: begin
                    if (mem.ready) begin
                        state <= mem.read_req ? ARB_RESP : ARB_IDLE;
                    end
                end
                ARB_RESP: begin
                    if (mem.read_data_valid) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/ram.sv ====
`timescale 1ns/1ps

module ram #(
    parameter int RAM_WORDS = 1024
) (
    input logic clk,
    input logic reset_n,
    mem_bus_if.slave bus
);
    import rv_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [31:0] mem [RAM_WORDS];
    logic [31:0] offset;
    logic [IDX_W-1:0] idx;

    // Word index relative to the RAM base.
    assign offset = bus.addr - RESET_PC;
    assign idx = offset[IDX_W+1:2];

    assign bus.ready = bus.read_req | bus.write_req;

    always_ff @(posedge clk) begin
        if (bus.write_req) begin
            for (int i = 0; i < 4; i++) begin
                if (bus.byte_enable[i]) begin
                    mem[idx][8*i +: 8] <= bus.write_data[8*i +: 8];
                end
            end
        end
        bus.read_data <= mem[idx];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            bus.read_data_valid <= 1'b0;
        end else begin
            bus.read_data_valid <= bus.read_req;
        end
    end

endmodule

// ==== verilog/soc_top.sv ====
`timescale 1ns/1ps

module soc_top #(
    parameter int RAM_WORDS = 1024
) (
    input logic clk,
    input logic reset_n,
    input logic [31:0] host_addr,
    input logic [31:0] host_write_data,
    input logic host_write,
    input logic host_read,
    output logic host_done,
    output logic [31:0] host_read_data,
    input logic run,
    output logic halted,
    output logic [31:0] halt_pc
);
    mem_bus_if host_bus ();
    mem_bus_if core_bus ();
    mem_bus_if ram_bus ();

    cpu u_cpu (
        .clk(clk),
        .reset_n(reset_n),
        .run(run),
        .bus(core_bus.master),
        .halted(halted),
        .halt_pc(halt_pc)
    );

    host_port u_host_port (
        .clk(clk),
        .reset_n(reset_n),
        .host_addr(host_addr),
        .host_write_data(host_write_data),
        .host_write(host_write),
        .host_read(host_read),
        .host_done(host_done),
        .host_read_data(host_read_data),
        .bus(host_bus.master)
    );

    // Host is m0 and the core is m1.
    bus_arbiter #(.RAM_WORDS(RAM_WORDS)) u_arbiter (
        .clk(clk),
        .reset_n(reset_n),
        .m0(host_bus.slave),
        .m1(core_bus.slave),
        .mem(ram_bus.master)
    );

    ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk(clk),
        .reset_n(reset_n),
        .bus(ram_bus.slave)
    );

endmodule

// ==== tb/tb_soc.sv ====
`timescale 1ns/1ps

module tb_soc;
    import rv_pkg::*;

    localparam int RAM_WORDS = 1024;
    // Program, results and preset data all live in the first 128 words.
    localparam int REGION = 128;
    // About four times the total length of all tests.
    localparam int TIMEOUT_CYCLES = 20000;

    logic clk;
    logic reset_n;
    logic [31:0] host_addr;
    logic [31:0] host_write_data;
    logic host_write;
    logic host_read;
    logic host_done;
    logic [31:0] host_read_data;
    logic run;
    logic halted;
    logic [31:0] halt_pc;

    int seed = 97219;
    int cycle_count = 0;
    int emit_idx;
    logic [31:0] ref_mem [RAM_WORDS];

    soc_top #(.RAM_WORDS(RAM_WORDS)) dut (
        .clk(clk),
        .reset_n(reset_n),
        .host_addr(host_addr),
        .host_write_data(host_write_data),
        .host_write(host_write),
        .host_read(host_read),
        .host_done(host_done),
        .host_read_data(host_read_data),
        .run(run),
        .halted(halted),
        .halt_pc(halt_pc)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch %s expected 0x%08h actual 0x%08h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch %s expected %b actual %b",
                                      name, expected, actual));
        end
    endtask

    // Instruction encoders.
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] opc, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] u_type(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, LUI};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    // Word index inside the RAM window.
    function automatic int word_index(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_PC;
        return (off >> 2) % RAM_WORDS;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr, input logic [31:0] salt);
        return {addr[15:0], addr[31:16]} ^ (addr << 3) ^ salt;
    endfunction

    // Instruction-set model over ref_mem that returns the halt address.
    function automatic logic [31:0] ref_run();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] i_imm;
        logic [31:0] s_imm;
        logic [31:0] j_imm;
        logic [4:0] rd;
        logic [2:0] f3;
        logic done;
        int steps;
        pc = RESET_PC;
        done = 1'b0;
        steps = 0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        while (!done && steps < 1000) begin
            ins = ref_mem[word_index(pc)];
            rd = ins[11:7];
            f3 = ins[14:12];
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            i_imm = {{20{ins[31]}}, ins[31:20]};
            s_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            j_imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            res = 32'h0;
            case (ins[6:0])
                OP_IMM: begin
                    if (f3 == 3'd0) res = a + i_imm;
                    else done = 1'b1;
                end
                OP: begin
                    case ({ins[31:25], f3})
                        {7'h00, 3'd0}: res = a + b;
                        {7'h20, 3'd0}: res = a - b;
                        {7'h00, 3'd7}: res = a & b;
                        {7'h00, 3'd6}: res = a | b;
                        {7'h00, 3'd4}: res = a ^ b;
                        {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: done = 1'b1;
                    endcase
                end
                LUI: res = {ins[31:12], 12'h0};
                JAL: res = pc + 32'h4;
                LOAD: begin
                    if (f3 == 3'd2) res = ref_mem[word_index(a + i_imm)];
                    else done = 1'b1;
                end
                STORE: begin
                    if (f3 == 3'd2) ref_mem[word_index(a + s_imm)] = b;
                    else done = 1'b1;
                end
                default: done = 1'b1;
            endcase
            if (!done) begin
                if (ins[6:0] != STORE && rd != 5'd0) regs[rd] = res;
                pc = (ins[6:0] == JAL) ? pc + j_imm : pc + 32'h4;
            end
            steps++;
        end
        return pc;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #5;
        reset_n = 1'b0;
        repeat (8) @(posedge clk);
        #5;
        reset_n = 1'b1;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #5;
        check_flag("host_done single pulse", 1'b0, host_done);
        host_addr = addr;
        host_write_data = data;
        host_write = 1'b1;
        @(posedge clk);
        #5;
        host_write = 1'b0;
        while (!host_done) begin
            @(posedge clk);
            #5;
        end
    endtask

    task automatic read_word(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #5;
        check_flag("host_done single pulse", 1'b0, host_done);
        host_addr = addr;
        host_read = 1'b1;
        @(posedge clk);
        #5;
        host_read = 1'b0;
        while (!host_done) begin
            @(posedge clk);
            #5;
        end
        data = host_read_data;
    endtask

    task automatic put_instr(input logic [31:0] word);
        ref_mem[emit_idx] = word;
        emit_idx++;
    endtask

    task automatic prepare_image(input logic [31:0] salt);
        emit_idx = 0;
        for (int i = 0; i < REGION; i++) begin
            ref_mem[i] = fill_word(RESET_PC + 4 * i, salt);
        end
    endtask

    task automatic start_program(input string name, output logic [31:0] exp_pc);
        apply_reset();
        for (int i = 0; i < REGION; i++) begin
            write_word(RESET_PC + 4 * i, ref_mem[i]);
        end
        exp_pc = ref_run();
        repeat (4) @(posedge clk);
        #5;
        check_flag($sformatf("%s halted before run", name), 1'b0, halted);
        run = 1'b1;
    endtask

    task automatic finish_program(input string name, input logic [31:0] exp_pc);
        logic [31:0] data;
        while (!halted) begin
            @(posedge clk);
            #5;
        end
        run = 1'b0;
        check_word($sformatf("%s halt_pc", name), exp_pc, halt_pc);
        for (int i = 0; i < REGION; i++) begin
            read_word(RESET_PC + 4 * i, data);
            check_word($sformatf("%s word %0d", name, i), ref_mem[i], data);
        end
    endtask

    // Register-register results go from 0x100 up with x5 as the RAM base.
    task automatic build_arith();
        logic [9:0] ops [6];
        logic [31:0] rnd;
        logic [11:0] off;
        ops = '{10'h000, 10'h100, 10'h007, 10'h006, 10'h004, 10'h002};
        put_instr(u_type(5'd5, 20'h10000));
        rnd = $random(seed);
        put_instr(u_type(5'd1, rnd[31:12]));
        rnd = $random(seed);
        put_instr(i_type(OP_IMM, 3'd0, 5'd1, 5'd1, rnd[11:0]));
        rnd = $random(seed);
        put_instr(u_type(5'd2, rnd[31:12]));
        rnd = $random(seed);
        put_instr(i_type(OP_IMM, 3'd0, 5'd2, 5'd2, rnd[11:0]));
        off = 12'h100;
        for (int k = 0; k < 6; k++) begin
            put_instr(r_type(ops[k][9:3], ops[k][2:0], 5'd3, 5'd1, 5'd2));
            put_instr(s_type(5'd5, 5'd3, off));
            off = off + 12'h4;
        end
        put_instr(r_type(7'h00, 3'd2, 5'd3, 5'd2, 5'd1));
        put_instr(s_type(5'd5, 5'd3, 12'h118));
        put_instr(s_type(5'd5, 5'd1, 12'h11c));
        put_instr(s_type(5'd5, 5'd2, 12'h120));
        put_instr(32'h0000_0073);
    endtask

    task automatic host_round_trip();
        logic [31:0] addrs [16];
        logic [31:0] vals [16];
        logic [31:0] rnd;
        logic [31:0] data;
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            addrs[i] = RESET_PC + 4 * (128 + 8 * i + rnd[2:0]);
            vals[i] = $random(seed);
            write_word(addrs[i], vals[i]);
        end
        for (int i = 0; i < 16; i++) begin
            read_word(addrs[i], data);
            check_word($sformatf("round trip %0d", i), vals[i], data);
        end
    endtask

    task automatic arith_program();
        logic [31:0] exp_pc;
        prepare_image(32'h1111_0000);
        build_arith();
        start_program("arith", exp_pc);
        finish_program("arith", exp_pc);
    endtask

    task automatic load_store_program();
        logic [31:0] exp_pc;
        logic [31:0] src0;
        logic [31:0] src1;
        logic [31:0] data;
        prepare_image(32'h2222_0000);
        src0 = $random(seed);
        src1 = $random(seed);
        ref_mem[80] = src0;
        ref_mem[81] = src1;
        put_instr(u_type(5'd5, 20'h10000));
        put_instr(i_type(LOAD, 3'd2, 5'd6, 5'd5, 12'h140));
        put_instr(i_type(LOAD, 3'd2, 5'd7, 5'd5, 12'h144));
        put_instr(r_type(7'h00, 3'd0, 5'd8, 5'd6, 5'd7));
        put_instr(r_type(7'h20, 3'd0, 5'd9, 5'd6, 5'd7));
        put_instr(s_type(5'd5, 5'd8, 12'h180));
        put_instr(s_type(5'd5, 5'd9, 12'h184));
        put_instr(s_type(5'd5, 5'd7, 12'h188));
        put_instr(i_type(LOAD, 3'd2, 5'd10, 5'd5, 12'h180));
        put_instr(r_type(7'h00, 3'd4, 5'd11, 5'd10, 5'd6));
        put_instr(s_type(5'd5, 5'd11, 12'h18c));
        put_instr(32'h0000_0073);
        start_program("load store", exp_pc);
        finish_program("load store", exp_pc);
        read_word(RESET_PC + 32'h140, data);
        check_word("load source 0", src0, data);
        read_word(RESET_PC + 32'h144, data);
        check_word("load source 1", src1, data);
    endtask

    task automatic jal_program();
        logic [31:0] exp_pc;
        logic [31:0] data;
        prepare_image(32'h3333_0000);
        put_instr(u_type(5'd5, 20'h10000));
        put_instr(j_type(5'd1, 21'd12));
        put_instr(s_type(5'd5, 5'd5, 12'h1c0));
        put_instr(s_type(5'd5, 5'd5, 12'h1c4));
        put_instr(s_type(5'd5, 5'd1, 12'h1c8));
        put_instr(j_type(5'd0, 21'd8));
        put_instr(s_type(5'd5, 5'd5, 12'h1cc));
        put_instr(32'h0000_0073);
        start_program("jal", exp_pc);
        finish_program("jal", exp_pc);
        read_word(RESET_PC + 32'h1c0, data);
        check_word("jal skipped store 0", fill_word(RESET_PC + 32'h1c0, 32'h3333_0000), data);
        read_word(RESET_PC + 32'h1cc, data);
        check_word("jal skipped store 1", fill_word(RESET_PC + 32'h1cc, 32'h3333_0000), data);
        // First jal is at word 1.
        read_word(RESET_PC + 32'h1c8, data);
        check_word("jal link", RESET_PC + 32'h4 + 32'h4, data);
    endtask

    task automatic halt_program();
        logic [31:0] exp_pc;
        prepare_image(32'h4444_0000);
        put_instr(u_type(5'd5, 20'h10000));
        put_instr(i_type(OP_IMM, 3'd0, 5'd1, 5'd0, 12'd5));
        put_instr(i_type(OP_IMM, 3'd0, 5'd2, 5'd1, 12'hffd));
        put_instr(s_type(5'd5, 5'd2, 12'h100));
        // mul is not supported.
        put_instr(r_type(7'h01, 3'd0, 5'd3, 5'd1, 5'd2));
        put_instr(s_type(5'd5, 5'd1, 12'h104));
        start_program("halt", exp_pc);
        finish_program("halt", exp_pc);
        repeat (5) @(posedge clk);
        #5;
        check_flag("halted held", 1'b1, halted);
    endtask

    task automatic contention_program();
        logic [31:0] exp_pc;
        logic [31:0] data;
        int reads;
        prepare_image(32'h5555_0000);
        build_arith();
        for (int i = 96; i < 112; i++) begin
            ref_mem[i] = $random(seed);
        end
        start_program("contention", exp_pc);
        reads = 0;
        while (!halted) begin
            read_word(RESET_PC + 4 * (96 + reads % 16), data);
            check_word($sformatf("contention read %0d", reads), ref_mem[96 + reads % 16], data);
            reads++;
        end
        finish_program("contention", exp_pc);
    endtask

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        host_addr = 32'h0;
        host_write_data = 32'h0;
        host_write = 1'b0;
        host_read = 1'b0;
        run = 1'b0;
        apply_reset();
        host_round_trip();
        arith_program();
        load_store_program();
        jal_program();
        halt_program();
        contention_program();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/rv_pkg.sv
verilog/mem_bus_if.sv
verilog/alu.sv
verilog/cpu.sv
verilog/host_port.sv
verilog/bus_arbiter.sv
verilog/ram.sv
verilog/soc_top.sv
tb/tb_soc.sv
